// File: hw/sa_defs.svh
`ifndef SA_DEFS_SVH
`define SA_DEFS_SVH

// grid size and datapath width of the systolic array
`define SA_ROWS 4
`define SA_COLS 4

`define SA_WORD 16  // operand and partial sum width

`endif

// File: hw/sa_pkg.sv
`default_nettype none

`include "sa_defs.svh"

package sa_pkg;

    typedef logic [`SA_WORD-1:0] word_t;

    typedef word_t [`SA_ROWS-1:0] row_bus_t;  // element r is row r
    typedef word_t [`SA_COLS-1:0] col_bus_t;  // element c is column c

    typedef logic [$clog2(`SA_ROWS)-1:0] row_idx_t;
    typedef row_idx_t [`SA_COLS-1:0] proxy_idx_bus_t;

    // raw control levels from the outside world
    typedef struct packed {
        logic stat_bit;
        logic out_select;
        logic op2_select;
    } ctl_t;

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_LOAD,
        MODE_MATMUL
    } pe_mode_e;

    typedef enum logic {
        PROXY_TBD,  // weights still coming in
        PROXY_SET
    } proxy_state_e;

endpackage

`default_nettype wire

// File: hw/ws_pe.sv
`default_nettype none

// weight-stationary MAC element
module ws_pe (
    input  logic             clk,
    input  logic             rst,
    input  sa_pkg::pe_mode_e mode,
    input  sa_pkg::word_t    top,
    input  sa_pkg::word_t    left,
    output sa_pkg::word_t    bottom,
    output sa_pkg::word_t    right
);

    sa_pkg::word_t weight_q;  // stationary operand
    sa_pkg::word_t sum_q;
    sa_pkg::word_t pass_q;    // left operand on its way right

    always_ff @(posedge clk) begin
        if (rst) begin
            weight_q <= '0;
            sum_q    <= '0;
            pass_q   <= '0;
        end else begin
            case (mode)
                sa_pkg::MODE_LOAD: begin
                    weight_q <= top;
                    // sum mirrors the new weight so the row below
                    // picks it up on the next load cycle
                    sum_q    <= top;
                end
                sa_pkg::MODE_MATMUL: begin
                    sum_q  <= top + left * weight_q;  // wraps at word width
                    pass_q <= left;
                end
                default: begin
                    // everything holds while idle
                end
            endcase
        end
    end

    assign bottom = sum_q;
    assign right  = pass_q;

endmodule

`default_nettype wire

// File: hw/ws_array.sv
`default_nettype none

`include "sa_defs.svh"

module ws_array (
    input  logic                   clk,
    input  logic                   rst,
    input  sa_pkg::pe_mode_e       mode,
    input  sa_pkg::row_bus_t       left_in,
    input  sa_pkg::col_bus_t       top_in,
    input  sa_pkg::proxy_idx_bus_t proxy_idx,
    output sa_pkg::col_bus_t       bottom_out,
    output sa_pkg::row_bus_t       right_out,
    output sa_pkg::col_bus_t       proxy_out
);

    // outputs of every PE, indexed [row][col]
    sa_pkg::word_t ver [`SA_ROWS][`SA_COLS];
    sa_pkg::word_t hor [`SA_ROWS][`SA_COLS];

    genvar r, c;
    generate
        for (r = 0; r < `SA_ROWS; r = r + 1) begin : row_genblk
            for (c = 0; c < `SA_COLS; c = c + 1) begin : col_genblk
                sa_pkg::word_t pe_top;
                sa_pkg::word_t pe_left;

                if (r == 0) begin : top_edge
                    assign pe_top = top_in[c];
                end else begin : top_peer
                    assign pe_top = ver[r-1][c];
                end

                if (c == 0) begin : left_edge
                    assign pe_left = left_in[r];
                end else begin : left_peer
                    assign pe_left = hor[r][c-1];
                end

                ws_pe u_pe (
                    .clk    (clk),
                    .rst    (rst),
                    .mode   (mode),
                    .top    (pe_top),
                    .left   (pe_left),
                    .bottom (ver[r][c]),
                    .right  (hor[r][c])
                );
            end
        end

        // array edges
        for (c = 0; c < `SA_COLS; c = c + 1) begin : bottom_genblk
            assign bottom_out[c] = ver[`SA_ROWS-1][c];
        end

        for (r = 0; r < `SA_ROWS; r = r + 1) begin : right_genblk
            assign right_out[r] = hor[r][`SA_COLS-1];
        end

        // tap the partial sum leaving each column's proxy row
        for (c = 0; c < `SA_COLS; c = c + 1) begin : proxy_genblk
            assign proxy_out[c] = ver[proxy_idx[c]][c];
        end
    endgenerate

endmodule

`default_nettype wire

// File: hw/array_control.sv
`default_nettype none

`include "sa_defs.svh"

// mode decode plus minimum-weight proxy tracking per column
module array_control (
    input  logic                   clk,
    input  logic                   rst,
    input  sa_pkg::ctl_t           ctl,
    input  sa_pkg::col_bus_t       top_in,
    output sa_pkg::pe_mode_e       mode,
    output sa_pkg::proxy_idx_bus_t proxy_idx,
    output logic [`SA_COLS-1:0]    proxy_valid
);

    sa_pkg::proxy_state_e   state_q;
    sa_pkg::row_idx_t       row_cnt_q;  // row the current load word ends up in
    sa_pkg::word_t          min_w_q [`SA_COLS];
    sa_pkg::proxy_idx_bus_t idx_q;
    logic [`SA_COLS-1:0]    found_q;    // column has seen its first weight
    logic [`SA_COLS-1:0]    take_min;
    logic                   tracking;

    always_comb begin
        if (ctl.op2_select && !ctl.out_select) begin
            mode = sa_pkg::MODE_LOAD;
        end else if (ctl.out_select && !ctl.op2_select && ctl.stat_bit) begin
            mode = sa_pkg::MODE_MATMUL;
        end else begin
            mode = sa_pkg::MODE_IDLE;
        end
    end

    assign tracking = (state_q == sa_pkg::PROXY_TBD) && (mode == sa_pkg::MODE_LOAD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= sa_pkg::PROXY_TBD;
            row_cnt_q <= sa_pkg::row_idx_t'(`SA_ROWS - 1);
        end else begin
            case (state_q)
                sa_pkg::PROXY_TBD: begin
                    if (mode == sa_pkg::MODE_LOAD) begin
                        row_cnt_q <= row_cnt_q - sa_pkg::row_idx_t'(1);
                        if (row_cnt_q == '0) begin  // last weight of the column
                            state_q <= sa_pkg::PROXY_SET;
                        end
                    end else if (mode == sa_pkg::MODE_MATMUL) begin
                        state_q <= sa_pkg::PROXY_SET;  // load cut short
                    end
                end
                default: begin
                    state_q <= sa_pkg::PROXY_SET;  // sticky until reset
                end
            endcase
        end
    end

    // strictly smaller only, so a tie keeps the higher row
    always_comb begin
        for (int c = 0; c < `SA_COLS; c++) begin
            take_min[c] = tracking && (!found_q[c] || (top_in[c] < min_w_q[c]));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            found_q <= '0;
            idx_q   <= '0;
        end else begin
            for (int c = 0; c < `SA_COLS; c++) begin
                if (take_min[c]) begin
                    found_q[c] <= 1'b1;
                    idx_q[c]   <= row_cnt_q;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < `SA_COLS; c++) begin
            if (take_min[c]) begin
                min_w_q[c] <= top_in[c];
            end
        end
    end

    assign proxy_idx = idx_q;

    always_comb begin
        for (int c = 0; c < `SA_COLS; c++) begin
            proxy_valid[c] = (state_q == sa_pkg::PROXY_SET) && found_q[c];
        end
    end

endmodule

`default_nettype wire

// File: hw/ws_systolic_top.sv
`default_nettype none

`include "sa_defs.svh"

module ws_systolic_top (
    input  logic                clk,
    input  logic                rst,
    input  sa_pkg::ctl_t        ctl,
    input  sa_pkg::row_bus_t    left_in,
    input  sa_pkg::col_bus_t    top_in,
    output sa_pkg::col_bus_t    bottom_out,
    output sa_pkg::row_bus_t    right_out,
    output sa_pkg::col_bus_t    proxy_out,
    output logic [`SA_COLS-1:0] proxy_valid
);

    sa_pkg::pe_mode_e       mode;       // shared by every PE
    sa_pkg::proxy_idx_bus_t proxy_idx;

    array_control u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ctl         (ctl),
        .top_in      (top_in),
        .mode        (mode),
        .proxy_idx   (proxy_idx),
        .proxy_valid (proxy_valid)
    );

    ws_array u_array (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .left_in    (left_in),
        .top_in     (top_in),
        .proxy_idx  (proxy_idx),
        .bottom_out (bottom_out),
        .right_out  (right_out),
        .proxy_out  (proxy_out)
    );

endmodule

`default_nettype wire

// File: bench/tb_checker.sv
`default_nettype none

`include "sa_defs.svh"

// watches the DUT ports and compares them with a model of the array
module tb_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic [2:0]          phase,
    input  sa_pkg::row_bus_t    left_in,
    input  sa_pkg::col_bus_t    top_in,
    input  sa_pkg::col_bus_t    bottom_out,
    input  sa_pkg::row_bus_t    right_out,
    input  sa_pkg::col_bus_t    proxy_out,
    input  logic [`SA_COLS-1:0] proxy_valid,
    output int                  error_count,
    output int                  check_count
);

    localparam logic [2:0] PH_RESET  = 3'd0;
    localparam logic [2:0] PH_LOAD   = 3'd1;
    localparam logic [2:0] PH_GAP    = 3'd2;
    localparam logic [2:0] PH_MATMUL = 3'd3;
    localparam logic [2:0] PH_HOLD   = 3'd4;
    localparam logic [2:0] PH_DONE   = 3'd5;

    localparam int SETTLE_CYCLES = `SA_ROWS + `SA_COLS;

    typedef sa_pkg::col_bus_t [`SA_ROWS-1:0] load_seq_t;  // element k is load cycle k

    typedef struct packed {
        sa_pkg::col_bus_t       bottom;
        sa_pkg::row_bus_t       right;
        sa_pkg::col_bus_t       proxy;
        sa_pkg::proxy_idx_bus_t proxy_row;
    } expect_t;

    load_seq_t        load_seq;
    sa_pkg::row_bus_t held_left;
    sa_pkg::col_bus_t held_top;
    expect_t          exp_q;
    logic             exp_ok = 1'b0;
    logic [2:0]       last_phase = PH_DONE;
    int               phase_cnt = 0;
    int               errors = 0;
    int               checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    function automatic expect_t predict(input load_seq_t seq, input sa_pkg::row_bus_t left,
                                        input sa_pkg::col_bus_t top);
        expect_t          res;
        sa_pkg::word_t    acc;
        sa_pkg::word_t    min_w;
        sa_pkg::row_idx_t min_row;
        res = '0;
        for (int c = 0; c < `SA_COLS; c++) begin
            // load cycle k ends in row ROWS-1-k and a strict compare keeps the earliest
            min_w   = seq[0][c];
            min_row = sa_pkg::row_idx_t'(`SA_ROWS - 1);
            for (int k = 1; k < `SA_ROWS; k++) begin
                if (seq[k][c] < min_w) begin
                    min_w   = seq[k][c];
                    min_row = sa_pkg::row_idx_t'(`SA_ROWS - 1 - k);
                end
            end
            res.proxy_row[c] = min_row;
            acc = top[c];
            for (int r = 0; r < `SA_ROWS; r++) begin
                acc = acc + left[r] * seq[`SA_ROWS - 1 - r][c];  // mod 2^WORD
                if (r == int'(min_row)) begin
                    res.proxy[c] = acc;
                end
            end
            res.bottom[c] = acc;
        end
        for (int r = 0; r < `SA_ROWS; r++) begin
            res.right[r] = left[r];
        end
        return res;
    endfunction

    task automatic check_word(input string name, input int idx, input sa_pkg::word_t want,
                              input sa_pkg::word_t got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t %s[%0d] expected %h got %h", $time, name, idx, want, got);
        end
    endtask

    task automatic check_valid(input logic [`SA_COLS-1:0] want);
        checks++;
        if (proxy_valid !== want) begin
            errors++;
            $display("[ERROR] %0t proxy_valid expected %b got %b", $time, want, proxy_valid);
        end
    endtask

    task automatic check_cleared();
        for (int c = 0; c < `SA_COLS; c++) begin
            check_word("bottom_out", c, '0, bottom_out[c]);
            check_word("proxy_out", c, '0, proxy_out[c]);
        end
        for (int r = 0; r < `SA_ROWS; r++) begin
            check_word("right_out", r, '0, right_out[r]);
        end
        check_valid('0);
    endtask

    task automatic check_results(input expect_t e);
        for (int c = 0; c < `SA_COLS; c++) begin
            check_word("bottom_out", c, e.bottom[c], bottom_out[c]);
            check_word("proxy_out", c, e.proxy[c], proxy_out[c]);
            if (proxy_out[c] !== e.proxy[c]) begin
                $display("  column %0d should tap row %0d", c, e.proxy_row[c]);
            end
        end
        for (int r = 0; r < `SA_ROWS; r++) begin
            check_word("right_out", r, e.right[r], right_out[r]);
        end
        check_valid('1);
    endtask

    // outputs seen here were settled by the previous edge
    always @(posedge clk) begin
        if (phase != last_phase) begin
            phase_cnt = 0;
        end else begin
            phase_cnt = phase_cnt + 1;
        end
        last_phase = phase;

        case (phase)
            PH_RESET: begin
                exp_ok = 1'b0;
                if (rst && phase_cnt >= 1) begin  // first edge still shows the old state
                    check_cleared();
                end
            end
            PH_LOAD: begin
                if (phase_cnt == 0) begin
                    check_cleared();
                end else begin
                    check_valid('0);
                end
                if (phase_cnt < `SA_ROWS) begin
                    load_seq[phase_cnt] = top_in;
                end
            end
            PH_GAP: check_valid('1);
            PH_MATMUL: begin
                if (phase_cnt == 0) begin
                    held_left = left_in;
                    held_top  = top_in;
                end
                if (phase_cnt >= SETTLE_CYCLES) begin
                    exp_q  = predict(load_seq, held_left, held_top);
                    exp_ok = 1'b1;
                    check_results(exp_q);
                end
            end
            PH_HOLD: begin
                if (exp_ok) begin
                    check_results(exp_q);  // idle must keep the last results
                end else begin
                    errors++;
                    $display("hold phase started before a matmul result had settled");
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
`default_nettype none

`include "sa_defs.svh"

module tb_top;

    localparam int NUM_TRIALS    = 8;
    localparam int RESET_CYCLES  = 10;
    localparam int GAP_CYCLES    = 2;
    localparam int MATMUL_CYCLES = `SA_ROWS + `SA_COLS + 2;  // settle plus two checked cycles
    localparam int HOLD_CYCLES   = 4;
    localparam int TRIAL_BUDGET  = 40;                       // one trial uses about 30
    localparam int MAX_CYCLES    = NUM_TRIALS * TRIAL_BUDGET + 80;

    // phase codes shared with tb_checker
    localparam logic [2:0] PH_RESET  = 3'd0;
    localparam logic [2:0] PH_LOAD   = 3'd1;
    localparam logic [2:0] PH_GAP    = 3'd2;
    localparam logic [2:0] PH_MATMUL = 3'd3;
    localparam logic [2:0] PH_HOLD   = 3'd4;
    localparam logic [2:0] PH_DONE   = 3'd5;

    localparam sa_pkg::ctl_t CTL_LOAD   = '{stat_bit: 1'b0, out_select: 1'b0, op2_select: 1'b1};
    localparam sa_pkg::ctl_t CTL_MATMUL = '{stat_bit: 1'b1, out_select: 1'b1, op2_select: 1'b0};

    logic                clk;
    logic                rst;
    sa_pkg::ctl_t        ctl;
    sa_pkg::row_bus_t    left_in;
    sa_pkg::col_bus_t    top_in;
    sa_pkg::col_bus_t    bottom_out;
    sa_pkg::row_bus_t    right_out;
    sa_pkg::col_bus_t    proxy_out;
    logic [`SA_COLS-1:0] proxy_valid;
    logic [2:0]          phase;
    int                  error_count;
    int                  check_count;
    int                  cycle_count = 0;

    ws_systolic_top UUT (
        .clk         (clk),
        .rst         (rst),
        .ctl         (ctl),
        .left_in     (left_in),
        .top_in      (top_in),
        .bottom_out  (bottom_out),
        .right_out   (right_out),
        .proxy_out   (proxy_out),
        .proxy_valid (proxy_valid)
    );

    tb_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .phase       (phase),
        .left_in     (left_in),
        .top_in      (top_in),
        .bottom_out  (bottom_out),
        .right_out   (right_out),
        .proxy_out   (proxy_out),
        .proxy_valid (proxy_valid),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic sa_pkg::row_bus_t random_row();
        sa_pkg::row_bus_t bus;
        for (int r = 0; r < `SA_ROWS; r++) begin
            bus[r] = sa_pkg::word_t'($urandom());
        end
        return bus;
    endfunction

    function automatic sa_pkg::col_bus_t random_col();
        sa_pkg::col_bus_t bus;
        for (int c = 0; c < `SA_COLS; c++) begin
            bus[c] = sa_pkg::word_t'($urandom());
        end
        return bus;
    endfunction

    // bits are stat_bit, out_select, op2_select; all of these decode to idle
    function automatic sa_pkg::ctl_t pick_idle_ctl();
        sa_pkg::ctl_t code;
        case ($urandom_range(4, 0))
            1: code = 3'b010;
            2: code = 3'b011;
            3: code = 3'b111;
            4: code = 3'b100;
            default: code = 3'b000;
        endcase
        return code;
    endfunction

    task automatic apply_reset();
        rst   = 1'b1;
        phase = PH_RESET;
        ctl   = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic load_weights(input bit with_tie);
        sa_pkg::col_bus_t seq [`SA_ROWS];
        int               ka;
        int               kb;
        for (int k = 0; k < `SA_ROWS; k++) begin
            seq[k] = random_col();
        end
        if (with_tie) begin
            // two load cycles share a nonzero value below every other weight of the column
            for (int c = 0; c < `SA_COLS; c++) begin
                ka = int'($urandom_range(`SA_ROWS - 1, 0));
                kb = (ka + 1 + int'($urandom_range(`SA_ROWS - 2, 0))) % `SA_ROWS;
                for (int k = 0; k < `SA_ROWS; k++) begin
                    seq[k][c] = seq[k][c] | 16'h0100;
                end
                seq[ka][c] = sa_pkg::word_t'($urandom_range(255, 1));
                seq[kb][c] = seq[ka][c];
            end
        end
        phase = PH_LOAD;
        ctl   = CTL_LOAD;
        for (int k = 0; k < `SA_ROWS; k++) begin
            top_in  = seq[k];
            left_in = random_row();  // ignored while loading
            @(negedge clk);
        end
    endtask

    task automatic idle_cycles(input logic [2:0] ph, input int n);
        phase = ph;
        for (int i = 0; i < n; i++) begin
            ctl     = pick_idle_ctl();
            left_in = random_row();
            top_in  = random_col();
            @(negedge clk);
        end
    endtask

    task automatic run_matmul();
        phase   = PH_MATMUL;
        ctl     = CTL_MATMUL;
        left_in = random_row();
        top_in  = random_col();
        repeat (MATMUL_CYCLES) @(negedge clk);
    endtask

    initial begin
        rst       = 1'b1;
        ctl       = '0;
        left_in   = '0;
        top_in    = '0;
        phase     = PH_RESET;
        void'($urandom(76412));
        for (int t = 0; t < NUM_TRIALS; t++) begin
            apply_reset();
            load_weights(t % 3 == 2);
            idle_cycles(PH_GAP, GAP_CYCLES);
            run_matmul();
            idle_cycles(PH_HOLD, HOLD_CYCLES);
        end
        phase = PH_DONE;
        repeat (2) @(negedge clk);
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            if (check_count == 0) begin
                $display("no comparisons were made during the run");
            end
            $display("CHECKS FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("checks run: %0d, errors: %0d", check_count, error_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/sa_pkg.sv
hw/ws_pe.sv
hw/ws_array.sv
hw/array_control.sv
hw/ws_systolic_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: Makefile
# Verilator build of the systolic array testbench
#   make compile   build the simulator
#   make run       build if needed, simulate, check the log
#   make clean     remove build output and log

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM      := $(BUILD_DIR)/V$(TOP)
PASS_MSG := ALL CHECKS PASSED
SRCS     := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
